// ==== rtl/rv_isa_pkg.sv ====
/* RV32I instruction encoding definitions
   Major opcodes, field positions and the fixed SYSTEM encodings */
package rv_isa_pkg;

   typedef enum logic [6:0] {
      OPC_LUI      = 7'b0110111,
      OPC_AUIPC    = 7'b0010111,
      OPC_JAL      = 7'b1101111,
      OPC_JALR     = 7'b1100111,
      OPC_BRANCH   = 7'b1100011,
      OPC_LOAD     = 7'b0000011,
      OPC_STORE    = 7'b0100011,
      OPC_OP_IMM   = 7'b0010011,
      OPC_OP       = 7'b0110011,
      OPC_MISC_MEM = 7'b0001111,
      OPC_SYSTEM   = 7'b1110011
   } opcode_t;

   // Field low bit and width
   localparam int OPCODE_L = 0;
   localparam int OPCODE_W = 7;
   localparam int RD_L     = 7;
   localparam int RD_W     = 5;
   localparam int F3_L     = 12;
   localparam int F3_W     = 3;
   localparam int RS1_L    = 15;
   localparam int RS1_W    = 5;
   localparam int RS2_L    = 20;
   localparam int RS2_W    = 5;
   localparam int F7_L     = 25;
   localparam int F7_W     = 7;
   localparam int I_IMM_L  = 20;
   localparam int I_IMM_W  = 12;

   localparam logic [F7_W-1:0] F7_BASE = 7'h00;
   localparam logic [F7_W-1:0] F7_ALT  = 7'h20;   // SUB, SRA, SRAI

   localparam logic [31:0] ECALL_IW  = 32'h0000_0073;
   localparam logic [31:0] EBREAK_IW = 32'h0010_0073;

   localparam logic [F7_W-1:0]  MRET_F7  = 7'h18;
   localparam logic [RS2_W-1:0] MRET_RS2 = 5'd2;
   localparam logic [F7_W-1:0]  WFI_F7   = 7'h08;
   localparam logic [RS2_W-1:0] WFI_RS2  = 5'd5;

endpackage

// ==== rtl/rv_exec_pkg.sv ====
/* Decoded result definitions
   Execute ops, operand sources, memory attributes and exception causes */
package rv_exec_pkg;

   localparam int XLEN = 32;

   typedef enum logic [3:0] {
      ADD, SUB, SLL, SRL, SRA, XOR, OR, AND,
      CMP_LT, CMP_EQ, CMP_NE, CMP_GE,
      JAL, JALR
   } exe_op_t;

   typedef enum logic [1:0] {
      S1_RS1, S1_PC, S1_ZERO, S1_UIMM
   } s1_src_t;

   typedef enum logic [1:0] {
      BYTE, HALF, WORD
   } mem_size_t;

   typedef logic [3:0] byteen_t;

   localparam byteen_t BE_B = 4'b0001;
   localparam byteen_t BE_H = 4'b0011;
   localparam byteen_t BE_W = 4'b1111;

   // mcause codes
   typedef enum logic [3:0] {
      ILLEGAL_INSTR = 4'd2,
      BREAKPOINT    = 4'd3,
      M_ECALL       = 4'd11
   } expn_code_t;

endpackage

// ==== rtl/decode_ifs.sv ====
/* Internal decode interfaces
   Control between the decoder stages, and the full packet into the register */
`timescale 1ns/1ps

interface decode_ctrl_if;
   import rv_exec_pkg::*;

   exe_op_t exe_op;
   s1_src_t s1_src;
   logic    needs_rs1;
   logic    needs_rs2;
   logic    gpr_wr_en;
   logic    illegal;

   modport producer (output exe_op, s1_src, needs_rs1, needs_rs2, gpr_wr_en, illegal);
   modport consumer (input exe_op, s1_src, needs_rs1, needs_rs2, gpr_wr_en, illegal);
endinterface

interface decode_payload_if;
   import rv_isa_pkg::*;
   import rv_exec_pkg::*;

   logic [XLEN-1:0] exe_s1, exe_s2, branch_tgt;
   exe_op_t         exe_op;
   logic            signed_cmp;
   mem_size_t       mem_size;
   byteen_t         mem_byteen;
   logic            mem_signext;
   logic [RD_W-1:0] rd;
   logic            needs_rs1, needs_rs2, gpr_wr_en;
   logic            csr_read, csr_set, csr_clr;
   logic            expn;
   expn_code_t      expn_type;

   modport producer (output exe_s1, exe_s2, exe_op, signed_cmp, mem_size, mem_byteen,
                     mem_signext, rd, needs_rs1, needs_rs2, gpr_wr_en, csr_read, csr_set,
                     csr_clr, branch_tgt, expn, expn_type);
   modport consumer (input exe_s1, exe_s2, exe_op, signed_cmp, mem_size, mem_byteen,
                     mem_signext, rd, needs_rs1, needs_rs2, gpr_wr_en, csr_read, csr_set,
                     csr_clr, branch_tgt, expn, expn_type);
endinterface

// ==== rtl/int_op_decoder.sv ====
/* Integer opcode decoder
   Control and legality for every RV32I class except SYSTEM */
`timescale 1ns/1ps

module int_op_decoder (
   input  logic [31:0]           iw,
   decode_ctrl_if.producer       ctrl
);
   import rv_isa_pkg::*;
   import rv_exec_pkg::*;

   opcode_t opc;
   logic    illegal;
   logic    writer;

   wire [F3_W-1:0]    f3    = iw[F3_L +: F3_W];
   wire [F7_W-1:0]    f7    = iw[F7_L +: F7_W];
   wire [RD_W-1:0]    rd    = iw[RD_L +: RD_W];
   wire [I_IMM_W-1:0] imm12 = iw[I_IMM_L +: I_IMM_W];
   wire [F7_W-1:0]    sh_f7 = imm12[I_IMM_W-1 -: F7_W];   // Shift type in top of immediate

   // Every major opcode ends in 2'b11, so short encodings fall to default
   assign opc = opcode_t'(iw[OPCODE_L +: OPCODE_W]);

   always_comb begin
      ctrl.exe_op    = ADD;
      ctrl.s1_src    = S1_RS1;
      ctrl.needs_rs1 = 1'b0;
      ctrl.needs_rs2 = 1'b0;
      illegal        = 1'b0;
      writer         = 1'b0;
      case (opc)
         OPC_LUI: begin
            ctrl.s1_src = S1_ZERO;
            writer      = 1'b1;
         end
         OPC_AUIPC: begin
            ctrl.s1_src = S1_PC;
            writer      = 1'b1;
         end
         OPC_JAL: begin
            ctrl.exe_op = JAL;
            writer      = 1'b1;
         end
         OPC_JALR: begin
            ctrl.exe_op    = JALR;
            ctrl.needs_rs1 = 1'b1;
            writer         = 1'b1;
            illegal        = (f3 != 3'd0);
         end
         OPC_BRANCH: begin
            ctrl.needs_rs1 = 1'b1;
            ctrl.needs_rs2 = 1'b1;
            case (f3)
               3'd0:       ctrl.exe_op = CMP_EQ;
               3'd1:       ctrl.exe_op = CMP_NE;
               3'd4, 3'd6: ctrl.exe_op = CMP_LT;   // BLT, BLTU
               3'd5, 3'd7: ctrl.exe_op = CMP_GE;
               default:    illegal = 1'b1;
            endcase
         end
         OPC_LOAD: begin
            ctrl.needs_rs1 = 1'b1;
            writer         = 1'b1;
            illegal        = (f3 == 3'd3) || (f3 > 3'd5);
         end
         OPC_STORE: begin
            ctrl.needs_rs1 = 1'b1;
            ctrl.needs_rs2 = 1'b1;
            illegal        = (f3 > 3'd2);
         end
         OPC_MISC_MEM: illegal = (f3 > 3'd1);     // FENCE, FENCE.I
         OPC_OP_IMM: begin
            ctrl.needs_rs1 = 1'b1;
            writer         = 1'b1;
            case (f3)
               3'd0:       ctrl.exe_op = ADD;
               3'd2, 3'd3: ctrl.exe_op = CMP_LT;
               3'd4:       ctrl.exe_op = XOR;
               3'd6:       ctrl.exe_op = OR;
               3'd7:       ctrl.exe_op = AND;
               3'd1: begin
                  ctrl.exe_op = SLL;
                  illegal     = (sh_f7 != F7_BASE);
               end
               default: begin
                  ctrl.exe_op = (sh_f7 == F7_ALT) ? SRA : SRL;
                  illegal     = (sh_f7 != F7_BASE) && (sh_f7 != F7_ALT);
               end
            endcase
         end
         OPC_OP: begin
            ctrl.needs_rs1 = 1'b1;
            ctrl.needs_rs2 = 1'b1;
            writer         = 1'b1;
            if (f7 == F7_BASE) begin
               case (f3)
                  3'd0:       ctrl.exe_op = ADD;
                  3'd1:       ctrl.exe_op = SLL;
                  3'd2, 3'd3: ctrl.exe_op = CMP_LT;   // SLT, SLTU
                  3'd4:       ctrl.exe_op = XOR;
                  3'd5:       ctrl.exe_op = SRL;
                  3'd6:       ctrl.exe_op = OR;
                  default:    ctrl.exe_op = AND;
               endcase
            end else if ((f7 == F7_ALT) && (f3 == 3'd0)) begin
               ctrl.exe_op = SUB;
            end else if ((f7 == F7_ALT) && (f3 == 3'd5)) begin
               ctrl.exe_op = SRA;
            end else begin
               illegal = 1'b1;
            end
         end
         default: illegal = 1'b1;               // SYSTEM is resolved downstream
      endcase
   end

   assign ctrl.illegal   = illegal;
   assign ctrl.gpr_wr_en = writer & ~illegal & (rd != '0);

endmodule

// ==== rtl/system_decoder.sv ====
/* SYSTEM instruction decoder
   Overrides control for SYSTEM words and forms the CSR and exception outputs */
`timescale 1ns/1ps

module system_decoder (
   input  logic [31:0]             iw,
   decode_ctrl_if.consumer         ctrl_in,
   decode_ctrl_if.producer         ctrl_out,
   output logic                    csr_read,
   output logic                    csr_set,
   output logic                    csr_clr,
   output logic                    expn,
   output rv_exec_pkg::expn_code_t expn_type
);
   import rv_isa_pkg::*;
   import rv_exec_pkg::*;

   logic illegal;

   wire [F3_W-1:0]  f3  = iw[F3_L +: F3_W];
   wire [F7_W-1:0]  f7  = iw[F7_L +: F7_W];
   wire [RS1_W-1:0] rs1 = iw[RS1_L +: RS1_W];
   wire [RS2_W-1:0] rs2 = iw[RS2_L +: RS2_W];
   wire [RD_W-1:0]  rd  = iw[RD_L +: RD_W];

   wire is_sys    = (iw[OPCODE_L +: OPCODE_W] == OPC_SYSTEM);
   wire is_ecall  = (iw == ECALL_IW);
   wire is_ebreak = (iw == EBREAK_IW);
   wire is_mret   = (f7 == MRET_F7) && (rs2 == MRET_RS2);
   wire is_wfi    = (f7 == WFI_F7) && (rs2 == WFI_RS2);
   wire priv_ok   = is_ecall | is_ebreak | ((rs1 == '0) & (rd == '0) & (is_mret | is_wfi));

   always_comb begin
      ctrl_out.exe_op    = ctrl_in.exe_op;
      ctrl_out.s1_src    = ctrl_in.s1_src;
      ctrl_out.needs_rs1 = ctrl_in.needs_rs1;
      ctrl_out.needs_rs2 = ctrl_in.needs_rs2;
      ctrl_out.gpr_wr_en = ctrl_in.gpr_wr_en;
      illegal            = ctrl_in.illegal;
      if (is_sys) begin
         ctrl_out.exe_op    = ADD;
         ctrl_out.s1_src    = f3[2] ? S1_UIMM : S1_RS1;
         ctrl_out.needs_rs1 = 1'b0;
         ctrl_out.needs_rs2 = 1'b0;
         ctrl_out.gpr_wr_en = 1'b0;
         case (f3)
            3'd0: illegal = ~priv_ok;
            3'd4: illegal = 1'b1;
            default: begin                      // CSR forms, old value always returned
               ctrl_out.needs_rs1 = ~f3[2];
               ctrl_out.gpr_wr_en = 1'b1;
               illegal            = 1'b0;
            end
         endcase
      end
   end

   assign ctrl_out.illegal = illegal;

   assign csr_read = is_sys & (f3[1:0] != 2'b00);
   assign csr_set  = (f3[1:0] == 2'b10);
   assign csr_clr  = (f3[1:0] == 2'b11);

   assign expn      = is_ecall | is_ebreak | illegal;
   assign expn_type = is_ecall  ? M_ECALL :
                      is_ebreak ? BREAKPOINT : ILLEGAL_INSTR;

endmodule

// ==== rtl/operand_mem_gen.sv ====
/* Operand and memory attribute generation
   Picks execute operands, computes branch target and load/store attributes */
`timescale 1ns/1ps

module operand_mem_gen (
   input  logic [rv_exec_pkg::XLEN-1:0] iw,
   input  logic [rv_exec_pkg::XLEN-1:0] imm,
   input  logic [rv_exec_pkg::XLEN-1:0] rs1_val,
   input  logic [rv_exec_pkg::XLEN-1:0] rs2_val,
   input  logic [rv_exec_pkg::XLEN-1:0] pc,
   input  logic                         use_imm,
   decode_ctrl_if.consumer              ctrl,
   input  logic                         csr_read,
   input  logic                         csr_set,
   input  logic                         csr_clr,
   input  logic                         expn,
   input  rv_exec_pkg::expn_code_t      expn_type,
   decode_payload_if.producer           out
);
   import rv_isa_pkg::*;
   import rv_exec_pkg::*;

   wire [F3_W-1:0] f3 = iw[F3_L +: F3_W];

   always_comb begin
      out.exe_s1 = rs1_val;
      case (ctrl.s1_src)
         S1_PC:   out.exe_s1 = pc;
         S1_ZERO: out.exe_s1 = '0;
         S1_UIMM: out.exe_s1 = {{(XLEN-RS1_W){1'b0}}, iw[RS1_L +: RS1_W]};   // CSR immediate
         default: out.exe_s1 = rs1_val;
      endcase
   end

   assign out.exe_s2     = use_imm ? imm : rs2_val;
   assign out.branch_tgt = pc + imm;

   always_comb begin
      case (f3[1:0])
         2'b00: begin
            out.mem_size   = BYTE;
            out.mem_byteen = BE_B;
         end
         2'b01: begin
            out.mem_size   = HALF;
            out.mem_byteen = BE_H;
         end
         default: begin
            out.mem_size   = WORD;
            out.mem_byteen = BE_W;
         end
      endcase
   end

   assign out.mem_signext = ~f3[2];
   assign out.signed_cmp  = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);   // Not the U forms
   assign out.rd          = iw[RD_L +: RD_W];

   assign out.exe_op    = ctrl.exe_op;
   assign out.needs_rs1 = ctrl.needs_rs1;
   assign out.needs_rs2 = ctrl.needs_rs2;
   assign out.gpr_wr_en = ctrl.gpr_wr_en & ~ctrl.illegal;   // A faulting word never writes

   assign out.csr_read  = csr_read;
   assign out.csr_set   = csr_set;
   assign out.csr_clr   = csr_clr;
   assign out.expn      = expn;
   assign out.expn_type = expn_type;

endmodule

// ==== rtl/decode_stage_reg.sv ====
/* Decode output register
   One-entry holding stage with valid/ready on both sides */
`timescale 1ns/1ps

module decode_stage_reg (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            in_valid,
   output logic                            in_ready,
   decode_payload_if.consumer              in,
   output logic                            out_valid,
   input  logic                            out_ready,
   output logic [rv_exec_pkg::XLEN-1:0]    exe_s1,
   output logic [rv_exec_pkg::XLEN-1:0]    exe_s2,
   output rv_exec_pkg::exe_op_t            exe_op,
   output logic                            signed_cmp,
   output rv_exec_pkg::mem_size_t          mem_size,
   output rv_exec_pkg::byteen_t            mem_byteen,
   output logic                            mem_signext,
   output logic [rv_isa_pkg::RD_W-1:0]     rd,
   output logic                            needs_rs1,
   output logic                            needs_rs2,
   output logic                            gpr_wr_en,
   output logic                            csr_read,
   output logic                            csr_set,
   output logic                            csr_clr,
   output logic [rv_exec_pkg::XLEN-1:0]    branch_tgt,
   output logic                            expn,
   output rv_exec_pkg::expn_code_t         expn_type
);

   logic full;

   wire take = in_valid & in_ready;

   assign in_ready  = ~full | out_ready;   // Accept while draining
   assign out_valid = full;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full <= 1'b0;
      end else if (take) begin
         full <= 1'b1;
      end else if (out_ready) begin
         full <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         exe_s1      <= in.exe_s1;
         exe_s2      <= in.exe_s2;
         exe_op      <= in.exe_op;
         signed_cmp  <= in.signed_cmp;
         mem_size    <= in.mem_size;
         mem_byteen  <= in.mem_byteen;
         mem_signext <= in.mem_signext;
         rd          <= in.rd;
         needs_rs1   <= in.needs_rs1;
         needs_rs2   <= in.needs_rs2;
         gpr_wr_en   <= in.gpr_wr_en;
         csr_read    <= in.csr_read;
         csr_set     <= in.csr_set;
         csr_clr     <= in.csr_clr;
         branch_tgt  <= in.branch_tgt;
         expn        <= in.expn;
         expn_type   <= in.expn_type;
      end
   end

endmodule

// ==== rtl/rv_decode_stage.sv ====
/* RV32I decode stage top
   Integer and SYSTEM decode followed by a one-entry output register */
`timescale 1ns/1ps

module rv_decode_stage (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            in_valid,
   output logic                            in_ready,
   input  logic [31:0]                     iw,
   input  logic [rv_exec_pkg::XLEN-1:0]    imm,
   input  logic                            use_imm,
   input  logic [rv_exec_pkg::XLEN-1:0]    rs1_val,
   input  logic [rv_exec_pkg::XLEN-1:0]    rs2_val,
   input  logic [rv_exec_pkg::XLEN-1:0]    pc,
   output logic                            out_valid,
   input  logic                            out_ready,
   output logic [rv_exec_pkg::XLEN-1:0]    exe_s1,
   output logic [rv_exec_pkg::XLEN-1:0]    exe_s2,
   output rv_exec_pkg::exe_op_t            exe_op,
   output logic                            signed_cmp,
   output rv_exec_pkg::mem_size_t          mem_size,
   output rv_exec_pkg::byteen_t            mem_byteen,
   output logic                            mem_signext,
   output logic [rv_isa_pkg::RD_W-1:0]     rd,
   output logic                            needs_rs1,
   output logic                            needs_rs2,
   output logic                            gpr_wr_en,
   output logic                            csr_read,
   output logic                            csr_set,
   output logic                            csr_clr,
   output logic [rv_exec_pkg::XLEN-1:0]    branch_tgt,
   output logic                            expn,
   output rv_exec_pkg::expn_code_t         expn_type
);
   import rv_exec_pkg::*;

   logic       sd_csr_read, sd_csr_set, sd_csr_clr;
   logic       sd_expn;
   expn_code_t sd_expn_type;

   decode_ctrl_if    ctrl_raw ();
   decode_ctrl_if    ctrl_fin ();
   decode_payload_if payload ();

   int_op_decoder u_int_op_decoder (.iw(iw), .ctrl(ctrl_raw));

   system_decoder u_system_decoder (
      .iw(iw), .ctrl_in(ctrl_raw), .ctrl_out(ctrl_fin),
      .csr_read(sd_csr_read), .csr_set(sd_csr_set), .csr_clr(sd_csr_clr),
      .expn(sd_expn), .expn_type(sd_expn_type)
   );

   operand_mem_gen u_operand_mem_gen (
      .iw(iw), .imm(imm), .rs1_val(rs1_val), .rs2_val(rs2_val), .pc(pc),
      .use_imm(use_imm), .ctrl(ctrl_fin),
      .csr_read(sd_csr_read), .csr_set(sd_csr_set), .csr_clr(sd_csr_clr),
      .expn(sd_expn), .expn_type(sd_expn_type), .out(payload)
   );

   decode_stage_reg u_decode_stage_reg (
      .clk(clk), .rst_n(rst_n),
      .in_valid(in_valid), .in_ready(in_ready), .in(payload),
      .out_valid(out_valid), .out_ready(out_ready),
      .exe_s1(exe_s1), .exe_s2(exe_s2), .exe_op(exe_op), .signed_cmp(signed_cmp),
      .mem_size(mem_size), .mem_byteen(mem_byteen), .mem_signext(mem_signext),
      .rd(rd), .needs_rs1(needs_rs1), .needs_rs2(needs_rs2), .gpr_wr_en(gpr_wr_en),
      .csr_read(csr_read), .csr_set(csr_set), .csr_clr(csr_clr),
      .branch_tgt(branch_tgt), .expn(expn), .expn_type(expn_type)
   );

endmodule

// ==== tb/rv_decode_assertions.sv ====
/* Handshake assertions for the decode output register */
`timescale 1ns/1ps

module rv_decode_assertions (
   input logic                         clk,
   input logic                         rst_n,
   input logic                         in_ready,
   input logic                         out_valid,
   input logic                         out_ready,
   input logic [rv_exec_pkg::XLEN-1:0] exe_s1,
   input logic [rv_exec_pkg::XLEN-1:0] exe_s2,
   input logic [rv_exec_pkg::XLEN-1:0] branch_tgt,
   input logic [3:0]                   exe_op,
   input logic [4:0]                   rd,
   input logic                         gpr_wr_en,
   input logic                         expn
);

   // Stalled packet stays put
   a_payload_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid &&
         $stable({exe_s1, exe_s2, branch_tgt, exe_op, rd, gpr_wr_en, expn}))
      else $error("payload changed while stalled");

   a_ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
      in_ready == (!out_valid || out_ready))
      else $error("in_ready does not follow out_valid and out_ready");

   a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
      else $error("out_valid high during reset");

endmodule

bind decode_stage_reg rv_decode_assertions u_rv_decode_assertions (
   .clk(clk), .rst_n(rst_n), .in_ready(in_ready), .out_valid(out_valid),
   .out_ready(out_ready), .exe_s1(exe_s1), .exe_s2(exe_s2), .branch_tgt(branch_tgt),
   .exe_op(exe_op), .rd(rd), .gpr_wr_en(gpr_wr_en), .expn(expn)
);

// ==== tb/tb_rv_decode.sv ====
/* Testbench for the RV32I decode stage
   Random instruction stream under back-pressure, checked against a decode model */
`timescale 1ns/1ps

module tb_rv_decode;
   import rv_isa_pkg::*;
   import rv_exec_pkg::*;

   localparam int NUM_TXN    = 2000;
   localparam int CLK_PERIOD = 100;
   localparam int RESET_CYC  = 10;
   localparam int FULL_RATE  = 200;   // Leading packets with out_ready held high

   typedef struct packed {
      logic [XLEN-1:0] exe_s1;
      logic [XLEN-1:0] exe_s2;
      logic [XLEN-1:0] branch_tgt;
      exe_op_t         exe_op;
      logic            signed_cmp;
      mem_size_t       mem_size;
      byteen_t         mem_byteen;
      logic            mem_signext;
      logic [RD_W-1:0] rd;
      logic            needs_rs1;
      logic            needs_rs2;
      logic            gpr_wr_en;
      logic            csr_read;
      logic            csr_set;
      logic            csr_clr;
      logic            expn;
      expn_code_t      expn_type;
   } pkt_t;

   logic            clk;
   logic            rst_n;
   logic            in_valid, in_ready, use_imm, out_valid, out_ready;
   logic [31:0]     iw;
   logic [XLEN-1:0] imm, rs1_val, rs2_val, pc;
   logic [XLEN-1:0] exe_s1, exe_s2, branch_tgt;
   exe_op_t         exe_op;
   logic            signed_cmp, mem_signext, needs_rs1, needs_rs2, gpr_wr_en;
   mem_size_t       mem_size;
   byteen_t         mem_byteen;
   logic [RD_W-1:0] rd;
   logic            csr_read, csr_set, csr_clr, expn;
   expn_code_t      expn_type;

   logic [31:0] rng_state;
   pkt_t        exp_q[$];   // Expected packets in acceptance order
   int          n_in;
   int          n_out;

   rv_decode_stage u_rv_decode_stage (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic abort_run();
      $display("SIMULATION FAILED");
      $fatal(1, "stopping on first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
         abort_run();
      end
   endtask

   function automatic exe_op_t base_alu_op(input logic [2:0] f3);
      case (f3)
         3'd0:       return ADD;
         3'd1:       return SLL;
         3'd2, 3'd3: return CMP_LT;
         3'd4:       return XOR;
         3'd5:       return SRL;
         3'd6:       return OR;
         default:    return AND;
      endcase
   endfunction

   // Weighted mix of legal encodings per class, plus fully random words
   function automatic logic [31:0] make_instr();
      logic [31:0] r;
      logic [31:0] w;
      logic [6:0]  f7;
      r  = next_rand();
      w  = next_rand();
      f7 = r[8] ? F7_ALT : F7_BASE;
      if (r[9:7] == 3'd0) begin
         f7 = r[31:25];   // Odd funct7 now and then
      end
      case (r[3:0])
         4'd0: w[6:0] = OPC_LUI;
         4'd1: w[6:0] = OPC_AUIPC;
         4'd2: w[6:0] = OPC_JAL;
         4'd3: begin
            w[6:0] = OPC_JALR;
            if (r[4]) begin
               w[14:12] = 3'd0;
            end
         end
         4'd4: w[6:0] = OPC_BRANCH;
         4'd5: w[6:0] = OPC_LOAD;
         4'd6: w[6:0] = OPC_STORE;
         4'd7, 4'd8: begin
            w[6:0] = OPC_OP_IMM;
            if (w[13:12] == 2'b01) begin
               w[31:25] = f7;   // Shifts
            end
         end
         4'd9, 4'd10: begin
            w[6:0]   = OPC_OP;
            w[31:25] = f7;
         end
         4'd11: w[6:0] = OPC_MISC_MEM;
         4'd12: w[6:0] = OPC_SYSTEM;
         4'd13: begin
            case (r[5:4])
               2'd0:    w = ECALL_IW;
               2'd1:    w = EBREAK_IW;
               2'd2:    w = {MRET_F7, MRET_RS2, 13'd0, OPC_SYSTEM};
               default: w = {WFI_F7, WFI_RS2, 13'd0, OPC_SYSTEM};
            endcase
            if (r[11:10] == 2'd0) begin
               w[19:15] = r[20:16];
            end
         end
         default: ;
      endcase
      if ((r[14:12] == 3'd0) && (r[3:0] != 4'd13)) begin
         w[11:7] = '0;
      end
      return w;
   endfunction

   function automatic pkt_t model_decode(input logic [31:0] w, input logic [XLEN-1:0] im,
                                         input logic ui, input logic [XLEN-1:0] a,
                                         input logic [XLEN-1:0] b, input logic [XLEN-1:0] pcv);
      pkt_t       p;
      s1_src_t    src;
      logic [2:0] f3;
      logic [6:0] f7;
      logic       bad;
      logic       writer;
      logic       csr_form;
      logic       priv_ok;
      f3       = w[14:12];
      f7       = w[31:25];
      p        = '0;
      src      = S1_RS1;
      bad      = 1'b0;
      writer   = 1'b0;
      csr_form = 1'b0;
      // MRET and WFI need rd, funct3 and rs1 all zero
      priv_ok  = (w == ECALL_IW) || (w == EBREAK_IW) ||
                 ((w[19:7] == '0) && (({f7, w[24:20]} == {MRET_F7, MRET_RS2}) ||
                                     ({f7, w[24:20]} == {WFI_F7, WFI_RS2})));
      case (w[6:0])
         OPC_LUI: begin
            src    = S1_ZERO;
            writer = 1'b1;
         end
         OPC_AUIPC: begin
            src    = S1_PC;
            writer = 1'b1;
         end
         OPC_JAL: begin
            p.exe_op = JAL;
            writer   = 1'b1;
         end
         OPC_JALR: begin
            p.exe_op    = JALR;
            p.needs_rs1 = 1'b1;
            writer      = 1'b1;
            bad         = (f3 != 3'd0);
         end
         OPC_BRANCH: begin
            p.needs_rs1 = 1'b1;
            p.needs_rs2 = 1'b1;
            case (f3)
               3'd0:       p.exe_op = CMP_EQ;
               3'd1:       p.exe_op = CMP_NE;
               3'd2, 3'd3: bad = 1'b1;
               3'd4, 3'd6: p.exe_op = CMP_LT;
               default:    p.exe_op = CMP_GE;
            endcase
         end
         OPC_LOAD: begin
            p.needs_rs1 = 1'b1;
            writer      = 1'b1;
            bad         = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
         end
         OPC_STORE: begin
            p.needs_rs1 = 1'b1;
            p.needs_rs2 = 1'b1;
            bad         = !(f3 inside {3'd0, 3'd1, 3'd2});
         end
         OPC_MISC_MEM: bad = (f3[2:1] != 2'b00);
         OPC_OP_IMM: begin
            p.needs_rs1 = 1'b1;
            writer      = 1'b1;
            p.exe_op    = base_alu_op(f3);
            if (f3 == 3'd1) begin
               bad = (f7 != F7_BASE);
            end else if (f3 == 3'd5) begin
               bad = (f7 != F7_BASE) && (f7 != F7_ALT);
               p.exe_op = (f7 == F7_ALT) ? SRA : SRL;
            end
         end
         OPC_OP: begin
            p.needs_rs1 = 1'b1;
            p.needs_rs2 = 1'b1;
            writer      = 1'b1;
            if (f7 == F7_BASE) begin
               p.exe_op = base_alu_op(f3);
            end else if ((f7 == F7_ALT) && (f3 == 3'd0)) begin
               p.exe_op = SUB;
            end else if ((f7 == F7_ALT) && (f3 == 3'd5)) begin
               p.exe_op = SRA;
            end else begin
               bad = 1'b1;
            end
         end
         OPC_SYSTEM: begin
            src = f3[2] ? S1_UIMM : S1_RS1;
            if (f3 == 3'd0) begin
               bad = !priv_ok;
            end else if (f3 == 3'd4) begin
               bad = 1'b1;
            end else begin
               csr_form    = 1'b1;
               p.needs_rs1 = !f3[2];
            end
            p.csr_read = (f3[1:0] != 2'b00);
         end
         default: bad = 1'b1;
      endcase
      p.gpr_wr_en   = csr_form || (writer && !bad && (w[11:7] != 5'd0));
      p.csr_set     = (f3[1:0] == 2'b10);   // Set and clear follow funct3 for any opcode
      p.csr_clr     = (f3[1:0] == 2'b11);
      p.expn        = bad || (w == ECALL_IW) || (w == EBREAK_IW);
      p.expn_type   = (w == ECALL_IW) ? M_ECALL : (w == EBREAK_IW) ? BREAKPOINT : ILLEGAL_INSTR;
      p.exe_s2      = ui ? im : b;
      p.branch_tgt  = pcv + im;
      p.signed_cmp  = (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
      p.mem_signext = !f3[2];
      p.rd          = w[11:7];
      case (src)
         S1_PC:   p.exe_s1 = pcv;
         S1_ZERO: p.exe_s1 = '0;
         S1_UIMM: p.exe_s1 = {27'd0, w[19:15]};
         default: p.exe_s1 = a;
      endcase
      case (f3[1:0])
         2'b00: begin
            p.mem_size   = BYTE;
            p.mem_byteen = BE_B;
         end
         2'b01: begin
            p.mem_size   = HALF;
            p.mem_byteen = BE_H;
         end
         default: begin
            p.mem_size   = WORD;
            p.mem_byteen = BE_W;
         end
      endcase
      return p;
   endfunction

   function automatic pkt_t sample_outputs();
      return '{exe_s1, exe_s2, branch_tgt, exe_op, signed_cmp, mem_size, mem_byteen,
               mem_signext, rd, needs_rs1, needs_rs2, gpr_wr_en, csr_read, csr_set,
               csr_clr, expn, expn_type};
   endfunction

   task automatic compare_packet(input pkt_t got, input pkt_t exp);
      check_value("exe_s1", got.exe_s1, exp.exe_s1);
      check_value("exe_s2", got.exe_s2, exp.exe_s2);
      check_value("branch_tgt", got.branch_tgt, exp.branch_tgt);
      check_value("exe_op", got.exe_op, exp.exe_op);
      check_value("signed_cmp", got.signed_cmp, exp.signed_cmp);
      check_value("mem_size", got.mem_size, exp.mem_size);
      check_value("mem_byteen", got.mem_byteen, exp.mem_byteen);
      check_value("mem_signext", got.mem_signext, exp.mem_signext);
      check_value("rd", got.rd, exp.rd);
      check_value("needs_rs1", got.needs_rs1, exp.needs_rs1);
      check_value("needs_rs2", got.needs_rs2, exp.needs_rs2);
      check_value("gpr_wr_en", got.gpr_wr_en, exp.gpr_wr_en);
      check_value("csr_read", got.csr_read, exp.csr_read);
      check_value("csr_set", got.csr_set, exp.csr_set);
      check_value("csr_clr", got.csr_clr, exp.csr_clr);
      check_value("expn", got.expn, exp.expn);
      check_value("expn_type", got.expn_type, exp.expn_type);
   endtask

   task automatic pop_and_compare(input pkt_t got);
      if (exp_q.size() == 0) begin
         $display("Error: output transfer with no packet outstanding");
         abort_run();
      end else begin
         compare_packet(got, exp_q.pop_front());
         n_out++;
      end
   endtask

   task automatic drive_next();
      logic [31:0] r;
      r = next_rand();
      if ((n_in < NUM_TXN) && (r[2:0] != 3'd0)) begin
         in_valid <= 1'b1;
         iw       <= make_instr();
         imm      <= next_rand();
         use_imm  <= r[8];
         rs1_val  <= next_rand();
         rs2_val  <= next_rand();
         pc       <= next_rand() & 32'hffff_fffc;
      end else begin
         in_valid <= 1'b0;
      end
   endtask

   initial begin : stimulus
      pkt_t cur;
      pkt_t held;
      logic accepted;
      logic accepted_last;
      logic stalled;
      rng_state     = 32'd88;
      n_in          = 0;
      n_out         = 0;
      held          = '0;
      accepted_last = 1'b0;
      stalled       = 1'b0;
      in_valid      = 1'b0;
      iw            = '0;
      imm           = '0;
      use_imm       = 1'b0;
      rs1_val       = '0;
      rs2_val       = '0;
      pc            = '0;
      out_ready     = 1'b0;   // Ready must come from the empty register
      rst_n        <= 1'b0;
      repeat (RESET_CYC) begin
         @(posedge clk);
         check_value("out_valid", out_valid, 1'b0);
         check_value("in_ready", in_ready, 1'b1);
      end
      rst_n <= 1'b1;
      @(posedge clk);
      check_value("out_valid", out_valid, 1'b0);
      check_value("in_ready", in_ready, 1'b1);
      out_ready <= 1'b1;
      drive_next();
      while (n_out < NUM_TXN) begin
         @(posedge clk);
         cur      = sample_outputs();
         accepted = in_valid && in_ready;
         check_value("in_ready", in_ready, !out_valid || out_ready);
         if (accepted_last || stalled) begin
            check_value("out_valid", out_valid, 1'b1);
         end
         if (stalled) begin
            compare_packet(cur, held);   // Held steady under back-pressure
         end
         if (out_valid && out_ready) begin
            pop_and_compare(cur);
         end
         if (accepted) begin
            exp_q.push_back(model_decode(iw, imm, use_imm, rs1_val, rs2_val, pc));
            n_in++;
         end
         accepted_last = accepted;
         stalled       = out_valid && !out_ready;
         held          = cur;
         if (!in_valid || accepted) begin
            drive_next();
         end
         out_ready <= (n_out < FULL_RATE) || (next_rand() % 3 != 0);
      end
      repeat (3) begin
         @(posedge clk);
         check_value("out_valid", out_valid, 1'b0);
      end
      $display("SIMULATION PASSED");
      $finish;
   end

   // Watchdog allows 20 cycles per packet plus slack
   initial begin
      repeat (NUM_TXN * 20 + 100) @(posedge clk);
      $display("Error: run timed out with %0d of %0d packets delivered", n_out, NUM_TXN);
      abort_run();
   end

endmodule

// ==== filelist.f ====
rtl/rv_isa_pkg.sv
rtl/rv_exec_pkg.sv
rtl/decode_ifs.sv
rtl/int_op_decoder.sv
rtl/system_decoder.sv
rtl/operand_mem_gen.sv
rtl/decode_stage_reg.sv
rtl/rv_decode_stage.sv
tb/rv_decode_assertions.sv
tb/tb_rv_decode.sv
